// ==== verilog/ahb_sram_params.svh ====
`ifndef AHB_SRAM_PARAMS_SVH
`define AHB_SRAM_PARAMS_SVH

////////////////////
// Bus widths
////////////////////

// AHB data bus
`define AHB_DWIDTH 32

// AHB address bus
`define AHB_AWIDTH 32

////////////////////
// SRAM geometry
////////////////////

// Byte address bits kept inside the SRAM, 1024 words
`define MEM_AWIDTH 12

// Wrap boundary mask, covers the largest wrap block
`define WRAP_MASK_W 11

`endif

// ==== verilog/ahb_sram_pkg.sv ====
package ahb_sram_pkg;

   // HTRANS encoding
   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      BUSY   = 2'b01,
      NONSEQ = 2'b10,
      SEQ    = 2'b11
   } htrans_t;

   // HBURST encoding
   typedef enum logic [2:0] {
      SINGLE = 3'b000,
      INCR   = 3'b001,
      WRAP4  = 3'b010,
      INCR4  = 3'b011,
      WRAP8  = 3'b100,
      INCR8  = 3'b101,
      WRAP16 = 3'b110,
      INCR16 = 3'b111
   } hburst_t;

   // HSIZE, anything above WORD handled as WORD
   typedef enum logic [2:0] {
      BYTE = 3'b000,
      HALF = 3'b001,
      WORD = 3'b010
   } hsize_t;

   // HRESP
   typedef enum logic [1:0] {
      OKAY  = 2'b00,
      ERROR = 2'b01
   } hresp_t;

   // Data phase state of the slave
   typedef enum logic [1:0] {
      ST_IDLE  = 2'b00,
      ST_WRITE = 2'b01,
      ST_READ  = 2'b10
   } slave_state_t;

endpackage

// ==== verilog/ahb_sram_ifs.sv ====
`timescale 1ns/1ns
`include "ahb_sram_params.svh"

////////////////////
// Command path
////////////////////

// Captured AHB command, from cmd_capture to addr_gen and port_ctrl
interface ahb_cmd_if (
   input logic HCLK,
   input logic aresetn
);
   import ahb_sram_pkg::*;

   // Valid NONSEQ this cycle
   logic                   accept;
   // SEQ beat while reading
   logic                   seq_beat;
   // Address phase values, only valid together with accept
   logic [`MEM_AWIDTH-1:0] start_addr;
   hsize_t                 start_size;
   hburst_t                start_burst;
   // Data phase levels
   logic                   wr_phase;
   logic                   rd_phase;
   // Write data phase attributes
   logic [`MEM_AWIDTH-1:0] wr_addr;
   hsize_t                 wr_size;

   modport cap (
      output accept, seq_beat, start_addr, start_size, start_burst,
      output wr_phase, rd_phase, wr_addr, wr_size
   );

   modport gen (
      input accept, seq_beat, start_addr, start_size, start_burst
   );

   // Clock and reset only for the checkers in port_ctrl
   modport ctl (
      input HCLK, aresetn, wr_phase, rd_phase, wr_addr, wr_size
   );

endinterface

////////////////////
// SRAM port
////////////////////

interface mem_req_if;

   logic [`MEM_AWIDTH-3:0]   word_addr;
   logic                     wen;
   logic                     ren;
   logic [`AHB_DWIDTH/8-1:0] byteen;
   logic [`AHB_DWIDTH-1:0]   wdata;
   logic [`AHB_DWIDTH-1:0]   rdata;

   modport master (output word_addr, wen, ren, byteen, wdata, input rdata);
   modport slave (input word_addr, wen, ren, byteen, wdata, output rdata);

endinterface

// ==== verilog/ahb_cmd_capture.sv ====
`timescale 1ns/1ns
`include "ahb_sram_params.svh"

module ahb_cmd_capture (
   input  logic                   HCLK,
   input  logic                   aresetn,
   input  logic                   hsel,
   input  logic                   hready,
   input  ahb_sram_pkg::htrans_t  htrans,
   input  ahb_sram_pkg::hburst_t  hburst,
   input  ahb_sram_pkg::hsize_t   hsize,
   input  logic                   hwrite,
   input  logic [`AHB_AWIDTH-1:0] haddr,
   output logic                   hreadyout,
   ahb_cmd_if.cap                 cmd
);
   import ahb_sram_pkg::*;

   slave_state_t state;
   slave_state_t state_nxt;
   logic         accept;
   logic         addr_done;
   logic         leave_req;
   logic         rd_wait;

   ////////////////////
   // Transfer decode
   ////////////////////

   // New transfer into this slave
   assign accept = hready & hreadyout & hsel & (htrans == NONSEQ);

   // Address phase of any NONSEQ or SEQ ends this cycle
   assign addr_done = hready & hsel & ((htrans == NONSEQ) | (htrans == SEQ));

   // IDLE, or the master moves on to another slave
   assign leave_req = (htrans == IDLE) | ((htrans == NONSEQ) & ~hsel);

   ////////////////////
   // Slave FSM
   ////////////////////

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (accept) begin
               state_nxt = hwrite ? ST_WRITE : ST_READ;
            end
         end
         ST_WRITE, ST_READ: begin
            if (leave_req) begin
               state_nxt = ST_IDLE;
            end
            else if (accept) begin
               // Direction may flip on a new NONSEQ
               state_nxt = hwrite ? ST_WRITE : ST_READ;
            end
         end
         default: begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge HCLK or negedge aresetn) begin
      if (!aresetn) begin
         state <= ST_IDLE;
      end
      else begin
         state <= state_nxt;
      end
   end

   // One wait state after each accepted NONSEQ read
   always_ff @(posedge HCLK or negedge aresetn) begin
      if (!aresetn) begin
         rd_wait <= 1'b0;
      end
      else begin
         rd_wait <= accept & ~hwrite;
      end
   end

   assign hreadyout = ~rd_wait;

   // Write attributes for the data phase
   // address follows every beat, size only the burst start
   always_ff @(posedge HCLK) begin
      if (addr_done) begin
         cmd.wr_addr <= haddr[`MEM_AWIDTH-1:0];
      end
      if (accept) begin
         cmd.wr_size <= hsize;
      end
   end

   ////////////////////
   // To addr_gen and port_ctrl
   ////////////////////

   assign cmd.accept      = accept;
   assign cmd.start_addr  = haddr[`MEM_AWIDTH-1:0];
   assign cmd.start_size  = hsize;
   assign cmd.start_burst = hburst;
   assign cmd.wr_phase    = (state == ST_WRITE);
   assign cmd.rd_phase    = (state == ST_READ);

   // SEQ steps the prefetch address, also in the own wait state
   // Held while another slave stalls the bus
   assign cmd.seq_beat = (state == ST_READ) & (htrans == SEQ) & (hready | ~hreadyout);

   // Wait state is one cycle, never two
   a_single_wait: assert property (
      @(posedge HCLK) disable iff (!aresetn) !hreadyout |=> hreadyout
   ) else $error("hreadyout low on two consecutive cycles");

endmodule

// ==== verilog/burst_addr_gen.sv ====
`timescale 1ns/1ns
`include "ahb_sram_params.svh"

module burst_addr_gen (
   input  logic                   HCLK,
   input  logic                   aresetn,
   ahb_cmd_if.gen                 cmd,
   output logic [`MEM_AWIDTH-1:0] rd_addr
);
   import ahb_sram_pkg::*;

   logic [1:0]              size_log2;
   logic [2:0]              start_incr;
   logic [`WRAP_MASK_W-1:0] beats;
   logic [`WRAP_MASK_W-1:0] start_mask;
   logic                    start_wrap;
   logic [2:0]              incr_q;
   logic [`WRAP_MASK_W-1:0] wrap_mask_q;
   logic                    wrap_en_q;
   logic [`MEM_AWIDTH-1:0]  addr_sum;
   logic [`MEM_AWIDTH-1:0]  addr_nxt;

   ////////////////////
   // Burst decode
   ////////////////////

   // Bytes per beat as a shift, sizes above word clamp to word
   always_comb begin
      case (cmd.start_size)
         BYTE:    size_log2 = 2'd0;
         HALF:    size_log2 = 2'd1;
         default: size_log2 = 2'd2;
      endcase
   end

   assign start_incr = 3'd1 << size_log2;

   // Beats in a fixed length burst
   always_comb begin
      case (cmd.start_burst)
         WRAP4, INCR4:   beats = `WRAP_MASK_W'(4);
         WRAP8, INCR8:   beats = `WRAP_MASK_W'(8);
         WRAP16, INCR16: beats = `WRAP_MASK_W'(16);
         default:        beats = `WRAP_MASK_W'(1);
      endcase
   end

   // Block size minus one, e.g. WRAP4 word gives 15
   assign start_mask = (beats << size_log2) - 1'b1;

   assign start_wrap = (cmd.start_burst == WRAP4) |
                       (cmd.start_burst == WRAP8) |
                       (cmd.start_burst == WRAP16);

   // Burst attributes held for the whole burst
   always_ff @(posedge HCLK or negedge aresetn) begin
      if (!aresetn) begin
         incr_q      <= 3'd0;
         wrap_mask_q <= '0;
         wrap_en_q   <= 1'b0;
      end
      else if (cmd.accept) begin
         incr_q      <= start_incr;
         wrap_mask_q <= start_mask;
         wrap_en_q   <= start_wrap;
      end
   end

   ////////////////////
   // Next address
   ////////////////////

   assign addr_sum = rd_addr + `MEM_AWIDTH'(incr_q);

   // Wrap: bits under the mask roll over to zero after the last beat,
   // bits above keep the block base
   always_comb begin
      addr_nxt = addr_sum;
      if (wrap_en_q) begin
         addr_nxt = rd_addr;
         addr_nxt[`WRAP_MASK_W-1:0] = (rd_addr[`WRAP_MASK_W-1:0] & ~wrap_mask_q) |
                                      (addr_sum[`WRAP_MASK_W-1:0] & wrap_mask_q);
      end
   end

   // New start wins over stepping
   always_ff @(posedge HCLK or negedge aresetn) begin
      if (!aresetn) begin
         rd_addr <= '0;
      end
      else if (cmd.accept) begin
         rd_addr <= cmd.start_addr;
      end
      else if (cmd.seq_beat) begin
         rd_addr <= addr_nxt;
      end
   end

endmodule

// ==== verilog/sram_port_ctrl.sv ====
`timescale 1ns/1ns
`include "ahb_sram_params.svh"

module sram_port_ctrl (
   ahb_cmd_if.ctl                 cmd,
   input  logic [`MEM_AWIDTH-1:0] rd_addr,
   input  logic [`AHB_DWIDTH-1:0] hwdata,
   output logic [`AHB_DWIDTH-1:0] hrdata,
   mem_req_if.master              mem
);
   import ahb_sram_pkg::*;

   logic [`MEM_AWIDTH-1:0] byte_addr;
   logic [3:0]             lane_sel;

   ////////////////////
   // Address and strobes
   ////////////////////

   // Write phase uses the latched address, else the prefetch counter
   assign byte_addr     = cmd.wr_phase ? cmd.wr_addr : rd_addr;
   assign mem.word_addr = byte_addr[`MEM_AWIDTH-1:2];

   assign mem.wen = cmd.wr_phase;
   assign mem.ren = cmd.rd_phase;

   // Lanes from size and low address bits
   always_comb begin
      case (cmd.wr_size)
         BYTE:    lane_sel = 4'b0001 << cmd.wr_addr[1:0];
         HALF:    lane_sel = cmd.wr_addr[1] ? 4'b1100 : 4'b0011;
         default: lane_sel = 4'b1111;
      endcase
   end

   assign mem.byteen = cmd.wr_phase ? lane_sel : 4'b0000;

   // Data straight through
   assign mem.wdata = hwdata;
   assign hrdata    = mem.rdata;

   ////////////////////
   // Checks
   ////////////////////

   // FSM phases never overlap at the SRAM
   a_wen_ren_excl: assert property (
      @(posedge cmd.HCLK) disable iff (!cmd.aresetn) !(mem.wen && mem.ren)
   ) else $error("wen and ren high together");

   // Lanes only with a write, and a write always hits a lane
   a_byteen_wen: assert property (
      @(posedge cmd.HCLK) disable iff (!cmd.aresetn) (mem.byteen != 4'b0000) == mem.wen
   ) else $error("byteen does not match wen");

endmodule

// ==== verilog/sram_bank.sv ====
`timescale 1ns/1ns
`include "ahb_sram_params.svh"

module sram_bank #(
   parameter int DEPTH_WORDS = 1024
) (
   input logic      HCLK,
   mem_req_if.slave mem
);

   localparam int IDX_W = $clog2(DEPTH_WORDS);
   localparam int LANES = `AHB_DWIDTH / 8;

   logic [`AHB_DWIDTH-1:0] ram [DEPTH_WORDS];
   logic [IDX_W-1:0]       idx;
   logic [`AHB_DWIDTH-1:0] rdata_q;

   // Word index, upper bits beyond the depth dropped
   assign idx = IDX_W'(mem.word_addr);

   // Per-byte write
   always_ff @(posedge HCLK) begin
      if (mem.wen) begin
         for (int i = 0; i < LANES; i++) begin
            if (mem.byteen[i]) begin
               ram[idx][8*i +: 8] <= mem.wdata[8*i +: 8];
            end
         end
      end
   end

   // Registered read, data one cycle after ren
   always_ff @(posedge HCLK) begin
      if (mem.ren) begin
         rdata_q <= ram[idx];
      end
   end

   assign mem.rdata = rdata_q;

endmodule

// ==== verilog/ahb_lsram_top.sv ====
`timescale 1ns/1ns
`include "ahb_sram_params.svh"

module ahb_lsram_top (
   input  logic                   HCLK,
   input  logic                   aresetn,
   input  logic                   hsel,
   input  logic                   hready,
   input  logic [1:0]             htrans,
   input  logic [2:0]             hburst,
   input  logic [2:0]             hsize,
   input  logic                   hwrite,
   input  logic [`AHB_AWIDTH-1:0] haddr,
   input  logic [`AHB_DWIDTH-1:0] hwdata,
   output logic                   hreadyout,
   output logic [1:0]             hresp,
   output logic [`AHB_DWIDTH-1:0] hrdata
);
   import ahb_sram_pkg::*;

   logic [`MEM_AWIDTH-1:0] rd_addr;

   ahb_cmd_if u_cmd_if (
      .HCLK    (HCLK),
      .aresetn (aresetn)
   );

   mem_req_if u_mem_if ();

   // No error responses
   assign hresp = OKAY;

   ////////////////////
   // Input side
   ////////////////////

   ahb_cmd_capture u_cmd_capture (
      .HCLK      (HCLK),
      .aresetn   (aresetn),
      .hsel      (hsel),
      .hready    (hready),
      .htrans    (htrans_t'(htrans)),
      .hburst    (hburst_t'(hburst)),
      .hsize     (hsize_t'(hsize)),
      .hwrite    (hwrite),
      .haddr     (haddr),
      .hreadyout (hreadyout),
      .cmd       (u_cmd_if.cap)
   );

   // Read address sequencing
   burst_addr_gen u_addr_gen (
      .HCLK    (HCLK),
      .aresetn (aresetn),
      .cmd     (u_cmd_if.gen),
      .rd_addr (rd_addr)
   );

   ////////////////////
   // Output side
   ////////////////////

   sram_port_ctrl u_port_ctrl (
      .cmd     (u_cmd_if.ctl),
      .rd_addr (rd_addr),
      .hwdata  (hwdata),
      .hrdata  (hrdata),
      .mem     (u_mem_if.master)
   );

   sram_bank #(
      .DEPTH_WORDS (2 ** (`MEM_AWIDTH - 2))
   ) u_sram (
      .HCLK (HCLK),
      .mem  (u_mem_if.slave)
   );

endmodule

// ==== verification/tb_ahb_lsram.sv ====
`timescale 1ns/1ns
`include "ahb_sram_params.svh"

module tb_ahb_lsram;
   import ahb_sram_pkg::*;

   localparam int N_ROWS  = 15;
   localparam int CLK_PER = 40;
   localparam int DRV_DLY = 2;

   // One table row is one AHB burst
   typedef struct packed {
      logic                   wr;
      hburst_t                burst;
      hsize_t                 size;
      logic [`MEM_AWIDTH-1:0] addr;
   } row_t;

   // One beat of a flattened burst
   typedef struct packed {
      logic                   wr;
      logic                   first;
      hburst_t                burst;
      hsize_t                 size;
      logic [`MEM_AWIDTH-1:0] addr;
   } beat_t;

   logic                   HCLK;
   logic                   aresetn;
   logic                   hsel;
   logic                   hready;
   htrans_t                htrans;
   hburst_t                hburst;
   hsize_t                 hsize;
   logic                   hwrite;
   logic [`AHB_AWIDTH-1:0] haddr;
   logic [`AHB_DWIDTH-1:0] hwdata;
   logic                   hreadyout;
   logic [1:0]             hresp;
   logic [`AHB_DWIDTH-1:0] hrdata;

   row_t                   tbl [N_ROWS];
   beat_t                  beats [$];
   logic [7:0]             shadow [1 << `MEM_AWIDTH];
   integer                 seed;

   ahb_lsram_top u_dut (
      .HCLK      (HCLK),
      .aresetn   (aresetn),
      .hsel      (hsel),
      .hready    (hready),
      .htrans    (htrans),
      .hburst    (hburst),
      .hsize     (hsize),
      .hwrite    (hwrite),
      .haddr     (haddr),
      .hwdata    (hwdata),
      .hreadyout (hreadyout),
      .hresp     (hresp),
      .hrdata    (hrdata)
   );

   // Single slave bus, HREADY comes back from this slave
   assign hready = hreadyout;

   initial HCLK = 1'b0;
   always #(CLK_PER / 2) HCLK = ~HCLK;

   ////////////////////
   // Helpers
   ////////////////////

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s: got 0x%08h, expected 0x%08h", $time, what, got, exp);
         $display("SOME TESTS FAILED");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   function automatic int size_bytes(input hsize_t size);
      case (size)
         BYTE:    return 1;
         HALF:    return 2;
         default: return 4;
      endcase
   endfunction

   function automatic int burst_len(input hburst_t burst);
      case (burst)
         WRAP4, INCR4:   return 4;
         WRAP8, INCR8:   return 8;
         WRAP16, INCR16: return 16;
         default:        return 1;
      endcase
   endfunction

   // Beat address, wrapping bursts stay in the aligned block of beats x size
   function automatic logic [`MEM_AWIDTH-1:0] beat_addr(input hburst_t burst,
         input hsize_t size, input logic [`MEM_AWIDTH-1:0] start, input int idx);
      int nb;
      int blk;
      nb  = size_bytes(size);
      blk = burst_len(burst) * nb;
      if (burst == WRAP4 || burst == WRAP8 || burst == WRAP16) begin
         return `MEM_AWIDTH'((int'(start) / blk) * blk + (int'(start) + idx * nb) % blk);
      end
      return `MEM_AWIDTH'(int'(start) + idx * nb);
   endfunction

   // Active byte lanes of a transfer
   function automatic logic [31:0] lane_mask(input hsize_t size,
                                             input logic [`MEM_AWIDTH-1:0] addr);
      case (size)
         BYTE:    return 32'h0000_00ff << (8 * addr[1:0]);
         HALF:    return 32'h0000_ffff << (16 * addr[1]);
         default: return 32'hffff_ffff;
      endcase
   endfunction

   task automatic shadow_write(input hsize_t size, input logic [`MEM_AWIDTH-1:0] addr,
                               input logic [31:0] data);
      logic [31:0] mask;
      mask = lane_mask(size, addr);
      for (int l = 0; l < 4; l++) begin
         if (mask[8*l]) begin
            shadow[{addr[`MEM_AWIDTH-1:2], 2'(l)}] = data[8*l +: 8];
         end
      end
   endtask

   function automatic logic [31:0] shadow_word(input logic [`MEM_AWIDTH-1:0] addr);
      logic [31:0] w;
      for (int l = 0; l < 4; l++) begin
         w[8*l +: 8] = shadow[{addr[`MEM_AWIDTH-1:2], 2'(l)}];
      end
      return w;
   endfunction

   ////////////////////
   // Watchdog
   ////////////////////

   initial begin
      #(N_ROWS * 20 * CLK_PER);
      $display("Timeout: simulation did not finish within the expected time");
      $display("SOME TESTS FAILED");
      $fatal(1, "watchdog expired");
   end

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin : main
      beat_t       b;
      beat_t       cur;
      logic        dphase;
      logic        dfirst;
      logic        exp_ready;
      logic [31:0] wdata;
      logic [31:0] mask;
      int          ai;
      int          cyc;

      seed    = 32'h971b_1f09;
      aresetn = 1'b0;
      hsel    = 1'b0;
      htrans  = IDLE;
      hburst  = SINGLE;
      hsize   = WORD;
      hwrite  = 1'b0;
      haddr   = '0;
      hwdata  = '0;

      // Known fill, so a read of unwritten SRAM shows up as a mismatch
      for (int a = 0; a < (1 << `MEM_AWIDTH); a++) begin
         shadow[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
      end

      // Write then read, lane writes, merged read-back, wraps, write then read
      tbl[0]  = '{1'b1, SINGLE, WORD, 12'h100};
      tbl[1]  = '{1'b0, SINGLE, WORD, 12'h100};
      tbl[2]  = '{1'b1, INCR4,  WORD, 12'h200};
      tbl[3]  = '{1'b1, SINGLE, BYTE, 12'h200};
      tbl[4]  = '{1'b1, SINGLE, BYTE, 12'h205};
      tbl[5]  = '{1'b1, SINGLE, BYTE, 12'h20a};
      tbl[6]  = '{1'b1, SINGLE, BYTE, 12'h20f};
      tbl[7]  = '{1'b1, SINGLE, HALF, 12'h202};
      tbl[8]  = '{1'b1, SINGLE, HALF, 12'h208};
      tbl[9]  = '{1'b0, INCR4,  WORD, 12'h200};
      tbl[10] = '{1'b1, INCR8,  WORD, 12'h300};
      tbl[11] = '{1'b0, WRAP4,  WORD, 12'h308};
      tbl[12] = '{1'b0, WRAP8,  HALF, 12'h316};
      tbl[13] = '{1'b1, SINGLE, WORD, 12'h30c};
      tbl[14] = '{1'b0, SINGLE, WORD, 12'h30c};

      // Flatten bursts into one beat stream
      for (int r = 0; r < N_ROWS; r++) begin
         for (int i = 0; i < burst_len(tbl[r].burst); i++) begin
            b.wr    = tbl[r].wr;
            b.first = (i == 0);
            b.burst = tbl[r].burst;
            b.size  = tbl[r].size;
            b.addr  = beat_addr(tbl[r].burst, tbl[r].size, tbl[r].addr, i);
            beats.push_back(b);
         end
      end

      repeat (3) @(posedge HCLK);
      #DRV_DLY;
      aresetn = 1'b1;
      @(negedge HCLK);
      check_value({31'b0, hreadyout}, 32'd1, "hreadyout after reset");
      check_value({30'b0, hresp}, {30'b0, OKAY}, "hresp after reset");
      @(posedge HCLK);
      #DRV_DLY;

      ai     = 0;
      cyc    = 0;
      dphase = 1'b0;
      dfirst = 1'b0;
      cur    = '0;
      wdata  = '0;
      // Pipelined master, address of the next beat overlaps the data phase
      while (ai < beats.size() || dphase) begin
         if (ai < beats.size()) begin
            hsel   = 1'b1;
            htrans = beats[ai].first ? NONSEQ : SEQ;
            hwrite = beats[ai].wr;
            hburst = beats[ai].burst;
            hsize  = beats[ai].size;
            haddr  = {{(`AHB_AWIDTH - `MEM_AWIDTH){1'b0}}, beats[ai].addr};
         end
         else begin
            htrans = IDLE;
            hwrite = 1'b0;
         end
         hwdata = (dphase && cur.wr) ? wdata : '0;
         @(negedge HCLK);

         // Only the first data cycle of a NONSEQ read waits
         exp_ready = !(dphase && !cur.wr && cur.first && dfirst);
         check_value({31'b0, hreadyout}, {31'b0, exp_ready},
                     $sformatf("hreadyout in cycle %0d", cyc));
         check_value({30'b0, hresp}, {30'b0, OKAY}, $sformatf("hresp in cycle %0d", cyc));

         if (hreadyout) begin
            if (dphase && cur.wr) begin
               shadow_write(cur.size, cur.addr, wdata);
            end
            else if (dphase) begin
               mask = lane_mask(cur.size, cur.addr);
               check_value(hrdata & mask, shadow_word(cur.addr) & mask,
                           $sformatf("read data at 0x%03h", cur.addr));
            end
            dphase = 1'b0;
            if (ai < beats.size()) begin
               cur    = beats[ai];
               ai     = ai + 1;
               dphase = 1'b1;
               dfirst = 1'b1;
               if (cur.wr) begin
                  wdata = $random(seed);
               end
            end
         end
         else begin
            dfirst = 1'b0;
         end
         cyc = cyc + 1;
         @(posedge HCLK);
         #DRV_DLY;
      end

      hsel   = 1'b0;
      htrans = IDLE;
      repeat (2) @(posedge HCLK);
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+verilog
verilog/ahb_sram_pkg.sv
verilog/ahb_sram_ifs.sv
verilog/ahb_cmd_capture.sv
verilog/burst_addr_gen.sv
verilog/sram_port_ctrl.sv
verilog/sram_bank.sv
verilog/ahb_lsram_top.sv
verification/tb_ahb_lsram.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AHB SRAM testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ns -f files.f \
      --top-module tb_ahb_lsram -o sim_tb; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"; then
   exit 0
else
   exit 1
fi
